//--- verilog.f
source/icache_cfg_pkg.sv
source/icache_types_pkg.sv
source/icache_ctrl.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_refill.sv
source/icache_top.sv
tb/tb_icache_mem.sv
tb/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - source/icache_cfg_pkg.sv
  - source/icache_types_pkg.sv
  - source/icache_ctrl.sv
  - source/icache_tag_array.sv
  - source/icache_data_array.sv
  - source/icache_refill.sv
  - source/icache_top.sv
  - target: test
    files:
      - tb/tb_icache_mem.sv
      - tb/tb_icache.sv

//--- tb/tb_icache.sv
/*
  Testbench of the instruction cache. Entries of the table run in order, so
  the expected request counts depend on what earlier entries left in the cache.
  Inputs change 1 ns after the rising edge and outputs are sampled at the falling edge.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_icache
  import icache_cfg_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 15;
  localparam int CYCLES_PER_TEST = 40;

  logic                clk;
  logic                rst_n;
  logic [ADDR_W-1:0]   inst_addr;
  logic                inst_cacheable;
  logic                inst_valid;
  logic                inst_ready;
  logic [FETCH_DW-1:0] inst_data;
  logic                inst_error;
  logic                flush_valid;
  logic                flush_ready;
  logic                mem_req_valid;
  logic [ADDR_W-1:0]   mem_req_addr;
  logic                mem_req_ready;
  logic                mem_rsp_valid;
  logic [LINE_W-1:0]   mem_rsp_data;
  logic                mem_rsp_error;
  int                  mem_accepted;

  string               test_name  [NUM_TESTS];
  bit                  test_flush [NUM_TESTS];
  logic [ADDR_W-1:0]   test_addr  [NUM_TESTS];
  bit                  test_cache [NUM_TESTS];
  logic [FETCH_DW-1:0] exp_data   [NUM_TESTS];
  bit                  exp_error  [NUM_TESTS];
  int                  exp_reqs   [NUM_TESTS];
  int                  num_entries;
  int                  check_errors;
  int                  cur_idx;

  icache_top dut_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .inst_addr_i(inst_addr), .inst_cacheable_i(inst_cacheable), .inst_valid_i(inst_valid),
    .inst_ready_o(inst_ready), .inst_data_o(inst_data), .inst_error_o(inst_error),
    .flush_valid_i(flush_valid), .flush_ready_o(flush_ready),
    .mem_req_valid_o(mem_req_valid), .mem_req_addr_o(mem_req_addr),
    .mem_req_ready_i(mem_req_ready),
    .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_data_i(mem_rsp_data),
    .mem_rsp_error_i(mem_rsp_error)
  );

  tb_icache_mem mem_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .req_valid_i(mem_req_valid), .req_addr_i(mem_req_addr), .req_ready_o(mem_req_ready),
    .rsp_valid_o(mem_rsp_valid), .rsp_data_o(mem_rsp_data), .rsp_error_o(mem_rsp_error),
    .accepted_o(mem_accepted)
  );

  // Each fetch word holds its own word-aligned byte address XOR a fixed pattern
  function automatic logic [FETCH_DW-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:2], 2'b00} ^ 32'hC0DE_0000;
  endfunction

  task automatic add_entry(input string name, input bit is_flush, input logic [ADDR_W-1:0] addr,
                           input bit cacheable, input bit error, input int reqs);
    test_name[num_entries]  = name;
    test_flush[num_entries] = is_flush;
    test_addr[num_entries]  = addr;
    test_cache[num_entries] = cacheable;
    exp_data[num_entries]   = expected_word(addr);
    exp_error[num_entries]  = error;
    exp_reqs[num_entries]   = reqs;
    num_entries++;
  endtask

  task automatic build_table();
    //        name                flush address        cache err reqs
    add_entry("cold_miss",          0, 32'h0000_0040, 1,    0,  1);
    add_entry("hit_word1",          0, 32'h0000_0044, 1,    0,  0);
    add_entry("hit_word3",          0, 32'h0000_004C, 1,    0,  0);
    add_entry("bypass",             0, 32'h0000_0250, 0,    0,  1);
    add_entry("bypass_no_alloc",    0, 32'h0000_0258, 1,    0,  1);
    add_entry("bypass_line_hit",    0, 32'h0000_025C, 1,    0,  0);
    add_entry("error_miss",         0, 32'h0000_1080, 1,    1,  1);
    add_entry("error_not_cached",   0, 32'h0000_1084, 1,    1,  1);
    add_entry("bypass_error",       0, 32'h0000_30C0, 0,    1,  1);
    // Index 4 again with another tag
    add_entry("evict",              0, 32'h0000_0840, 1,    0,  1);
    add_entry("evicted_miss",       0, 32'h0000_0044, 1,    0,  1);
    add_entry("refilled_hit",       0, 32'h0000_0048, 1,    0,  0);
    add_entry("flush",              1, 32'h0000_0000, 0,    0,  0);
    add_entry("flushed_miss",       0, 32'h0000_004C, 1,    0,  1);
    add_entry("flushed_other_miss", 0, 32'h0000_0254, 1,    0,  1);
  endtask

  task automatic report_value(input int idx, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
    $display("FAILED %s: %s expected 0x%0h, actual 0x%0h",
             test_name[idx], what, expected, actual);
    check_errors++;
  endtask

  task automatic run_entry(input int idx);
    int                  cycles;
    int                  reqs_before;
    int                  errors_before;
    logic [FETCH_DW-1:0] got_data;
    logic                got_error;
    cur_idx       = idx;
    reqs_before   = mem_accepted;
    errors_before = check_errors;
    @(posedge clk);
    #1;
    if (test_flush[idx]) begin
      flush_valid = 1'b1;
    end else begin
      inst_addr      = test_addr[idx];
      inst_cacheable = test_cache[idx];
      inst_valid     = 1'b1;
    end
    cycles = 0;
    @(negedge clk);
    while (!(test_flush[idx] ? flush_ready : inst_ready)) begin
      cycles++;
      @(negedge clk);
    end
    got_data  = inst_data;
    got_error = inst_error;
    @(posedge clk);
    #1;
    inst_valid  = 1'b0;
    flush_valid = 1'b0;
    if (test_flush[idx]) begin
      assert (cycles == 1) else report_value(idx, "flush latency", 1, cycles);
    end else begin
      assert (got_error == exp_error[idx])
      else report_value(idx, "error", exp_error[idx], got_error);
      if (!exp_error[idx]) begin
        assert (got_data == exp_data[idx])
        else report_value(idx, "data", exp_data[idx], got_data);
      end
      // A hit answers exactly two cycles after the fetch is sampled
      if (exp_reqs[idx] == 0) begin
        assert (cycles == 2) else report_value(idx, "hit latency", 2, cycles);
      end
    end
    assert (mem_accepted - reqs_before == exp_reqs[idx])
    else report_value(idx, "memory requests", exp_reqs[idx], mem_accepted - reqs_before);
    if (check_errors == errors_before) begin
      $display("pass  %s (%0d cycles)", test_name[idx], cycles);
    end else begin
      $display("fail  %s", test_name[idx]);
    end
  endtask

  // An accepted request must ask for the aligned line of the running fetch
  always @(negedge clk) begin
    if (rst_n && mem_req_valid && mem_req_ready) begin
      assert (mem_req_addr == (test_addr[cur_idx] & 32'hFFFF_FFF0))
      else report_value(cur_idx, "memory address", test_addr[cur_idx] & 32'hFFFF_FFF0,
                        mem_req_addr);
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    $display("Timeout, the DUT stopped responding to a fetch or flush");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst_n          = 1'b0;
    inst_addr      = '0;
    inst_cacheable = 1'b0;
    inst_valid     = 1'b0;
    flush_valid    = 1'b0;
    num_entries    = 0;
    check_errors   = 0;
    cur_idx        = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (!inst_ready && !flush_ready && !mem_req_valid)
    else begin
      $display("Ready or memory request outputs are high right after reset");
      check_errors++;
    end
    for (int idx = 0; idx < num_entries; idx++) begin
      run_entry(idx);
    end
    $display("Tests run: %0d, failed checks: %0d", num_entries, check_errors);
    if (check_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_icache_mem.sv
/*
  Behavioral line memory for the cache testbench. Serves one request at a
  time, stalls ready for 0 to 3 cycles and answers 1 to 4 cycles after accept.
  Word w of line A holds (A + 4w) ^ 32'hC0DE_0000, address bit 12 flags an error.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_icache_mem
  import icache_cfg_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_n_i,
  input  wire                req_valid_i,
  input  wire  [ADDR_W-1:0]  req_addr_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output logic [LINE_W-1:0]  rsp_data_o,
  output logic               rsp_error_o,
  output int                 accepted_o
);

  integer seed = 32'h4644_c2b8;

  initial begin
    int                delay;
    logic [ADDR_W-1:0] addr;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rsp_error_o = 1'b0;
    accepted_o  = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_n_i && req_valid_i) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk_i);
        #1 req_ready_o = 1'b1;
        addr = req_addr_i;
        // The request is accepted on this edge
        @(posedge clk_i);
        #1 req_ready_o = 1'b0;
        accepted_o = accepted_o + 1;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk_i);
        #1;
        for (int word_idx = 0; word_idx < LINE_W / FETCH_DW; word_idx++) begin
          rsp_data_o[word_idx * FETCH_DW +: FETCH_DW] = (addr + 4 * word_idx) ^ 32'hC0DE_0000;
        end
        rsp_error_o = addr[12];
        rsp_valid_o = 1'b1;
        @(posedge clk_i);
        #1 rsp_valid_o = 1'b0;
        rsp_error_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/icache_top.sv
/*
  Single-port direct-mapped instruction cache with an uncacheable bypass.
  The core holds address and cacheable flag until inst_ready_o pulses.
  One line request is outstanding at a time; the response has no back-pressure.
  Lines that return a memory error are never allocated.
*/
`timescale 1ns/100ps
`default_nettype none

module icache_top
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  wire                 clk_i,
  input  wire                 rst_n_i,

  input  wire  [ADDR_W-1:0]   inst_addr_i,
  input  wire                 inst_cacheable_i,
  input  wire                 inst_valid_i,
  output logic                inst_ready_o,
  output logic [FETCH_DW-1:0] inst_data_o,
  output logic                inst_error_o,

  input  wire                 flush_valid_i,
  output logic                flush_ready_o,

  output logic                mem_req_valid_o,
  output logic [ADDR_W-1:0]   mem_req_addr_o,
  input  wire                 mem_req_ready_i,

  input  wire                 mem_rsp_valid_i,
  input  wire  [LINE_W-1:0]   mem_rsp_data_i,
  input  wire                 mem_rsp_error_i
);

  fetch_addr_u       fetch_addr;
  logic              hit;
  logic              lookup_en;
  logic              alloc_en;
  logic              flush_en;
  logic              refill_start;
  logic              respond_sel;
  logic              refill_done;
  logic              refill_error;
  logic [LINE_W-1:0] refill_line;

  assign fetch_addr = inst_addr_i;

  // The captured memory error is the fetch error, it is low outside a refill response
  assign inst_error_o = refill_error;

  icache_ctrl i_ctrl (
    .clk_i, .rst_n_i, .inst_valid_i, .inst_cacheable_i, .flush_valid_i,
    .hit_i         (hit),
    .refill_done_i (refill_done),
    .refill_error_i(refill_error),
    .inst_ready_o, .flush_ready_o,
    .lookup_en_o   (lookup_en),
    .refill_start_o(refill_start),
    .alloc_en_o    (alloc_en),
    .flush_en_o    (flush_en),
    .respond_sel_o (respond_sel)
  );

  icache_tag_array i_tag_array (
    .clk_i, .rst_n_i,
    .addr_i     (fetch_addr),
    .lookup_en_i(lookup_en),
    .alloc_en_i (alloc_en),
    .flush_en_i (flush_en),
    .hit_o      (hit)
  );

  icache_data_array i_data_array (
    .clk_i,
    .addr_i       (fetch_addr),
    .alloc_en_i   (alloc_en),
    .refill_line_i(refill_line),
    .respond_sel_i(respond_sel),
    .inst_data_o
  );

  icache_refill i_refill (
    .clk_i, .rst_n_i,
    .addr_i        (fetch_addr),
    .refill_start_i(refill_start),
    .mem_req_ready_i, .mem_rsp_valid_i, .mem_rsp_data_i, .mem_rsp_error_i,
    .mem_req_valid_o, .mem_req_addr_o,
    .refill_done_o (refill_done),
    .refill_line_o (refill_line),
    .refill_error_o(refill_error)
  );

endmodule

`default_nettype wire

//--- source/icache_refill.sv
/*
  Memory side of the cache. Issues one line-aligned request per refill and
  holds it until accepted. The response strobe has no back-pressure.
  The error flag is only valid in the cycle after the response.
*/
`timescale 1ns/100ps
`default_nettype none

module icache_refill
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire fetch_addr_u    addr_i,
  input  wire                 refill_start_i,
  input  wire                 mem_req_ready_i,
  input  wire                 mem_rsp_valid_i,
  input  wire  [LINE_W-1:0]   mem_rsp_data_i,
  input  wire                 mem_rsp_error_i,
  output logic                mem_req_valid_o,
  output logic [ADDR_W-1:0]   mem_req_addr_o,
  output logic                refill_done_o,
  output logic [LINE_W-1:0]   refill_line_o,
  output logic                refill_error_o
);

  logic wait_q;

  // Only a response to an accepted request counts
  assign refill_done_o = wait_q && mem_rsp_valid_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_req_valid_o <= 1'b0;
      wait_q          <= 1'b0;
      refill_error_o  <= 1'b0;
    end else begin
      if (refill_start_i) begin
        mem_req_valid_o <= 1'b1;
      end else if (mem_req_ready_i) begin
        mem_req_valid_o <= 1'b0;
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        wait_q <= 1'b1;
      end else if (mem_rsp_valid_i) begin
        wait_q <= 1'b0;
      end
      refill_error_o <= refill_done_o && mem_rsp_error_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_start_i) begin
      mem_req_addr_o <= {addr_i.raw[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
    if (refill_done_o) begin
      refill_line_o <= mem_rsp_data_i;
    end
  end

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o))
    else $error("Memory request changed before it was accepted");

  a_one_outstanding : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    refill_start_i |-> !mem_req_valid_o && !wait_q)
    else $error("Refill started while another one is in flight");

endmodule

`default_nettype wire

//--- source/icache_data_array.sv
/*
  Line storage of the cache. The fetch word comes from the stored line
  or, right after a refill, straight from the refill line.
  Storage content is undefined until a line is allocated.
*/
`timescale 1ns/100ps
`default_nettype none

module icache_data_array
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  wire                 clk_i,
  input  wire fetch_addr_u    addr_i,
  input  wire                 alloc_en_i,
  input  wire  [LINE_W-1:0]   refill_line_i,
  input  wire                 respond_sel_i,
  output logic [FETCH_DW-1:0] inst_data_o
);

  logic [LINE_W-1:0] line_q [LINE_COUNT];
  logic [LINE_W-1:0] src_line;

  always_ff @(posedge clk_i) begin
    if (alloc_en_i) begin
      line_q[addr_i.cache.index] <= refill_line_i;
    end
  end

  // A refill response is served from the refill unit while the line is written
  assign src_line = respond_sel_i ? refill_line_i : line_q[addr_i.cache.index];

  // Word 0 sits in the low bits of the line
  assign inst_data_o = src_line[addr_i.cache.word * FETCH_DW +: FETCH_DW];

endmodule

`default_nettype wire

//--- source/icache_tag_array.sv
/*
  Valid bits and tags of the direct-mapped cache. Hit is combinational
  and only reported while lookup is enabled. Flush clears all lines at once.
*/
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_n_i,
  input  wire fetch_addr_u addr_i,
  input  wire              lookup_en_i,
  input  wire              alloc_en_i,
  input  wire              flush_en_i,
  output logic             hit_o
);

  logic [LINE_COUNT-1:0] valid_q;
  logic [TAG_W-1:0]      tag_q [LINE_COUNT];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_en_i) begin
      valid_q <= '0;
    end else if (alloc_en_i) begin
      valid_q[addr_i.cache.index] <= 1'b1;
    end
  end

  // Tags mean nothing until their valid bit is set
  always_ff @(posedge clk_i) begin
    if (alloc_en_i) begin
      tag_q[addr_i.cache.index] <= addr_i.cache.tag;
    end
  end

  assign hit_o = lookup_en_i && valid_q[addr_i.cache.index] &&
                 (tag_q[addr_i.cache.index] == addr_i.cache.tag);

  // Flush has priority and would silently drop an allocation in the same cycle
  a_alloc_flush_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(alloc_en_i && flush_en_i))
    else $error("Line allocation collides with flush");

endmodule

`default_nettype wire

//--- source/icache_ctrl.sv
/*
  Cache controller FSM. A hit answers two cycles after the fetch is sampled.
  Flush is only taken in IDLE and wins over a waiting fetch.
  The fetch inputs must stay stable until inst_ready_o.
*/
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl
  import icache_types_pkg::*;
(
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  inst_valid_i,
  input  wire  inst_cacheable_i,
  input  wire  flush_valid_i,
  input  wire  hit_i,
  input  wire  refill_done_i,
  input  wire  refill_error_i,
  output logic inst_ready_o,
  output logic flush_ready_o,
  output logic lookup_en_o,
  output logic refill_start_o,
  output logic alloc_en_o,
  output logic flush_en_o,
  output logic respond_sel_o
);

  ctrl_state_e state_q, state_d;
  logic        sel_q, sel_d;

  always_comb begin
    state_d        = state_q;
    sel_d          = sel_q;
    inst_ready_o   = 1'b0;
    flush_ready_o  = 1'b0;
    lookup_en_o    = 1'b0;
    refill_start_o = 1'b0;
    alloc_en_o     = 1'b0;
    flush_en_o     = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (flush_valid_i) begin
          state_d = FLUSH;
        end else if (inst_valid_i && inst_cacheable_i) begin
          state_d = LOOKUP;
        end else if (inst_valid_i) begin
          // Uncacheable fetches skip the lookup
          state_d = REFILL_REQ;
          sel_d   = 1'b1;
        end
      end
      LOOKUP: begin
        lookup_en_o = 1'b1;
        if (hit_i) begin
          state_d = RESPOND;
          sel_d   = 1'b0;
        end else begin
          state_d = REFILL_REQ;
          sel_d   = 1'b1;
        end
      end
      REFILL_REQ: begin
        refill_start_o = 1'b1;
        state_d        = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        if (refill_done_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        inst_ready_o = 1'b1;
        // Only a clean refill of a cacheable fetch is written into the arrays
        alloc_en_o   = sel_q && inst_cacheable_i && !refill_error_i;
        state_d      = IDLE;
      end
      FLUSH: begin
        flush_en_o    = 1'b1;
        flush_ready_o = 1'b1;
        state_d       = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  assign respond_sel_o = sel_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      sel_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      sel_q   <= sel_d;
    end
  end

  // The core must still be waiting when the response is given
  a_ready_with_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inst_ready_o |-> inst_valid_i)
    else $error("inst_ready_o without a pending fetch");

endmodule

`default_nettype wire

//--- source/icache_types_pkg.sv
/*
  Shared types of the cache. The fetch address union assumes the geometry
  of icache_cfg_pkg. Its two views always cover the same 32 bits.
*/
`default_nettype none

package icache_types_pkg;

  import icache_cfg_pkg::*;

  // Address split as the arrays see it
  typedef struct packed {
    logic [TAG_W-1:0]               tag;
    logic [INDEX_W-1:0]             index;
    logic [WORD_SEL_W-1:0]          word;
    logic [OFFSET_W-WORD_SEL_W-1:0] byte_sel;
  } cache_addr_t;

  typedef union packed {
    cache_addr_t       cache;
    logic [ADDR_W-1:0] raw;
  } fetch_addr_u;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND,
    FLUSH
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/icache_cfg_pkg.sv
/*
  Geometry of the instruction cache. The address layout in icache_types_pkg
  is built from these values, so the cache works with this geometry only.
*/
`default_nettype none

package icache_cfg_pkg;

  // Fetch side
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned FETCH_DW = 32;

  // Direct-mapped array of LINE_COUNT lines
  localparam int unsigned LINE_W     = 128;
  localparam int unsigned LINE_COUNT = 16;

  // Byte offset inside one line
  localparam int unsigned OFFSET_W = $clog2(LINE_W / 8);

  // Fetch word index, the upper bits of the line offset
  localparam int unsigned WORD_SEL_W = $clog2(LINE_W / FETCH_DW);

  localparam int unsigned INDEX_W = $clog2(LINE_COUNT);

  // Everything above index and offset is tag
  localparam int unsigned TAG_W = ADDR_W - INDEX_W - OFFSET_W;

endpackage

`default_nettype wire
